// ==== source/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define XLEN        32
`define REG_AW      5
`define RESET_PC    32'h0000_0000
`define ALU_OP_W    4

// Instruction fields
`define OPC_HI      6
`define OPC_LO      0
`define RD_HI       11
`define RD_LO       7
`define F3_HI       14
`define F3_LO       12
`define RS1_HI      19
`define RS1_LO      15
`define RS2_HI      24
`define RS2_LO      20
`define F7_SUB      30      // Picks sub over add

`define EBREAK_WORD 32'h0010_0073

`endif

// ==== source/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD,                // Must stay zero for bubbles
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_LT} br_type_e;
    typedef enum logic [1:0] {WD_ALU, WD_PC4, WD_LOAD} wd_sel_e;
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef struct packed {
        logic     rs1_re;
        logic     rs2_re;
        logic     reg_we;
        wd_sel_e  wd_sel;
        logic     src1_pc;
        logic     src2_imm;
        alu_op_e  alu_op;
        br_type_e br_type;
        logic     jal;
        logic     mem_we;
        logic     mem_re;
        logic     ebreak;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   rs1_data;
        logic [`XLEN-1:0]   rs2_data;
        logic [`XLEN-1:0]   imm;
        ctrl_t              ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0]   result;
        logic [`XLEN-1:0]   store_data;
        logic [`REG_AW-1:0] rd;
        ctrl_t              ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [`XLEN-1:0]   result;
        logic [`XLEN-1:0]   load_data;
        logic [`REG_AW-1:0] rd;
        ctrl_t              ctrl;
    } mem_wb_t;

endpackage

// ==== source/hazard_if.sv ====
`include "cpu_macros.svh"

interface hazard_if;
    logic [`REG_AW-1:0] rs1_id, rs2_id;
    logic               rs1_re_id, rs2_re_id;
    logic [`REG_AW-1:0] rs1_ex, rs2_ex, rd_ex;
    logic               rs1_re_ex, rs2_re_ex;
    logic               mem_read_ex;
    logic [`REG_AW-1:0] rd_mem, rd_wb;
    logic               reg_we_mem, reg_we_wb;
    logic               redirect_ex;
    cpu_pkg::fwd_sel_e  fwd_a, fwd_b;
    logic               stall, flush;

    modport hazard (
        input  rs1_id, rs2_id, rs1_re_id, rs2_re_id,
        input  rs1_ex, rs2_ex, rs1_re_ex, rs2_re_ex, rd_ex, mem_read_ex,
        input  rd_mem, reg_we_mem, rd_wb, reg_we_wb, redirect_ex,
        output fwd_a, fwd_b, stall, flush
    );
    modport pipe (
        output rs1_id, rs2_id, rs1_re_id, rs2_re_id,
        output rs1_ex, rs2_ex, rs1_re_ex, rs2_re_ex, rd_ex, mem_read_ex,
        output rd_mem, reg_we_mem, rd_wb, reg_we_wb,
        input  stall, flush
    );
    modport exec (output redirect_ex, input fwd_a, fwd_b);
endinterface

// ==== source/decoder.sv ====
`include "cpu_macros.svh"

module decoder (
    input  logic [`XLEN-1:0] inst,
    output cpu_pkg::ctrl_t   ctrl,
    output logic [`XLEN-1:0] imm
);
    cpu_pkg::opcode_e opcode;
    logic [2:0]       funct3;
    cpu_pkg::alu_op_e arith_op;
    logic             arith_ok;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = cpu_pkg::opcode_e'(inst[`OPC_HI:`OPC_LO]);
    assign funct3 = inst[`F3_HI:`F3_LO];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Shared by OP and OP_IMM
    always_comb begin
        arith_ok = 1'b1;
        arith_op = cpu_pkg::ALU_ADD;
        case (funct3)
            3'b000: begin
                if (opcode == cpu_pkg::OPC_OP && inst[`F7_SUB]) begin
                    arith_op = cpu_pkg::ALU_SUB;
                end
            end
            3'b010:  arith_op = cpu_pkg::ALU_SLT;
            3'b100:  arith_op = cpu_pkg::ALU_XOR;
            3'b110:  arith_op = cpu_pkg::ALU_OR;
            3'b111:  arith_op = cpu_pkg::ALU_AND;
            default: arith_ok = 1'b0;   // Shifts and sltu not supported
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            cpu_pkg::OPC_OP: begin
                ctrl.rs1_re = arith_ok;
                ctrl.rs2_re = arith_ok;
                ctrl.reg_we = arith_ok;
                ctrl.alu_op = arith_op;
            end
            cpu_pkg::OPC_OP_IMM: begin
                ctrl.rs1_re   = arith_ok;
                ctrl.reg_we   = arith_ok;
                ctrl.src2_imm = arith_ok;
                ctrl.alu_op   = arith_op;
                imm           = imm_i;
            end
            cpu_pkg::OPC_LUI: begin
                ctrl.reg_we   = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.alu_op   = cpu_pkg::ALU_PASS_B;
                imm           = imm_u;
            end
            cpu_pkg::OPC_LOAD: begin
                if (funct3 == 3'b010) begin     // lw only
                    ctrl.rs1_re   = 1'b1;
                    ctrl.reg_we   = 1'b1;
                    ctrl.wd_sel   = cpu_pkg::WD_LOAD;
                    ctrl.src2_imm = 1'b1;
                    ctrl.mem_re   = 1'b1;
                end
                imm = imm_i;
            end
            cpu_pkg::OPC_STORE: begin
                if (funct3 == 3'b010) begin     // sw only
                    ctrl.rs1_re   = 1'b1;
                    ctrl.rs2_re   = 1'b1;
                    ctrl.src2_imm = 1'b1;
                    ctrl.mem_we   = 1'b1;
                end
                imm = imm_s;
            end
            cpu_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000:  ctrl.br_type = cpu_pkg::BR_EQ;
                    3'b001:  ctrl.br_type = cpu_pkg::BR_NE;
                    3'b100:  ctrl.br_type = cpu_pkg::BR_LT;
                    default: ctrl.br_type = cpu_pkg::BR_NONE;
                endcase
                if (ctrl.br_type != cpu_pkg::BR_NONE) begin
                    ctrl.rs1_re   = 1'b1;
                    ctrl.rs2_re   = 1'b1;
                    ctrl.src1_pc  = 1'b1;   // ALU forms the target
                    ctrl.src2_imm = 1'b1;
                end
                imm = imm_b;
            end
            cpu_pkg::OPC_JAL: begin
                ctrl.reg_we   = 1'b1;
                ctrl.wd_sel   = cpu_pkg::WD_PC4;
                ctrl.src1_pc  = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.jal      = 1'b1;
                imm           = imm_j;
            end
            cpu_pkg::OPC_SYSTEM: ctrl.ebreak = (inst == `EBREAK_WORD);
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== source/reg_file.sv ====
`include "cpu_macros.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] ra0,
    input  logic [`REG_AW-1:0] ra1,
    input  logic [`REG_AW-1:0] dbg_addr,
    output logic [`XLEN-1:0]   rd0,
    output logic [`XLEN-1:0]   rd1,
    output logic [`XLEN-1:0]   dbg_data,
    input  logic [`REG_AW-1:0] wa,
    input  logic [`XLEN-1:0]   wd,
    input  logic               we
);
    logic [`XLEN-1:0] regs [2**`REG_AW];

    // Write-first so ID sees the value retiring in WB
    function automatic logic [`XLEN-1:0] read_port(
        input logic [`REG_AW-1:0] ra,
        input logic               w_en,
        input logic [`REG_AW-1:0] w_addr,
        input logic [`XLEN-1:0]   w_data,
        input logic [`XLEN-1:0]   stored
    );
        if (ra == '0) begin
            return '0;
        end
        return (w_en && w_addr == ra) ? w_data : stored;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**`REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd0      = read_port(ra0, we, wa, wd, regs[ra0]);
        rd1      = read_port(ra1, we, wa, wd, regs[ra1]);
        dbg_data = read_port(dbg_addr, we, wa, wd, regs[dbg_addr]);
    end

endmodule

// ==== source/execute.sv ====
`include "cpu_macros.svh"

module execute (
    input  cpu_pkg::id_ex_t  ex,
    input  logic [`XLEN-1:0] mem_result,
    input  logic [`XLEN-1:0] wb_result,
    hazard_if.exec           haz,
    output logic [`XLEN-1:0] result,
    output logic [`XLEN-1:0] store_data,
    output logic             redirect,
    output logic [`XLEN-1:0] target
);
    logic [`XLEN-1:0] op_a, op_b;
    logic [`XLEN-1:0] src1, src2;
    logic [`XLEN-1:0] alu_out;
    logic             taken;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input cpu_pkg::fwd_sel_e sel,
        input logic [`XLEN-1:0]  rf_val,
        input logic [`XLEN-1:0]  mem_val,
        input logic [`XLEN-1:0]  wb_val
    );
        case (sel)
            cpu_pkg::FWD_MEM: return mem_val;
            cpu_pkg::FWD_WB:  return wb_val;
            default:          return rf_val;
        endcase
    endfunction

    always_comb begin
        op_a = fwd_mux(haz.fwd_a, ex.rs1_data, mem_result, wb_result);
        op_b = fwd_mux(haz.fwd_b, ex.rs2_data, mem_result, wb_result);
        src1 = ex.ctrl.src1_pc ? ex.pc : op_a;
        src2 = ex.ctrl.src2_imm ? ex.imm : op_b;
    end

    always_comb begin
        case (ex.ctrl.alu_op)
            cpu_pkg::ALU_ADD:    alu_out = src1 + src2;
            cpu_pkg::ALU_SUB:    alu_out = src1 - src2;
            cpu_pkg::ALU_AND:    alu_out = src1 & src2;
            cpu_pkg::ALU_OR:     alu_out = src1 | src2;
            cpu_pkg::ALU_XOR:    alu_out = src1 ^ src2;
            cpu_pkg::ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            cpu_pkg::ALU_PASS_B: alu_out = src2;
            default:             alu_out = '0;
        endcase
    end

    // Branch compare always on the forwarded registers
    always_comb begin
        case (ex.ctrl.br_type)
            cpu_pkg::BR_EQ: taken = (op_a == op_b);
            cpu_pkg::BR_NE: taken = (op_a != op_b);
            cpu_pkg::BR_LT: taken = ($signed(op_a) < $signed(op_b));
            default:        taken = 1'b0;
        endcase
    end

    assign target     = alu_out;        // pc + imm for branches and jal
    assign redirect   = ex.ctrl.jal || taken;
    assign store_data = op_b;
    assign result     = (ex.ctrl.wd_sel == cpu_pkg::WD_PC4) ? ex.pc + `XLEN'(4) : alu_out;

    assign haz.redirect_ex = redirect;

endmodule

// ==== source/hazard_unit.sv ====
`include "cpu_macros.svh"

module hazard_unit (
    hazard_if.hazard haz
);
    logic load_use;

    // MEM is the younger producer, so it wins over WB
    function automatic cpu_pkg::fwd_sel_e fwd_pick(
        input logic               re,
        input logic [`REG_AW-1:0] rs,
        input logic               we_mem,
        input logic [`REG_AW-1:0] rd_mem,
        input logic               we_wb,
        input logic [`REG_AW-1:0] rd_wb
    );
        if (!re || rs == '0) begin
            return cpu_pkg::FWD_NONE;
        end
        if (we_mem && rd_mem == rs) begin
            return cpu_pkg::FWD_MEM;
        end
        if (we_wb && rd_wb == rs) begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_NONE;
    endfunction

    always_comb begin
        haz.fwd_a = fwd_pick(haz.rs1_re_ex, haz.rs1_ex, haz.reg_we_mem, haz.rd_mem,
                             haz.reg_we_wb, haz.rd_wb);
        haz.fwd_b = fwd_pick(haz.rs2_re_ex, haz.rs2_ex, haz.reg_we_mem, haz.rd_mem,
                             haz.reg_we_wb, haz.rd_wb);
    end

    // Load in EX feeding the instruction in ID
    assign load_use = haz.mem_read_ex && haz.rd_ex != '0 &&
                      ((haz.rs1_re_id && haz.rs1_id == haz.rd_ex) ||
                       (haz.rs2_re_id && haz.rs2_id == haz.rd_ex));

    assign haz.stall = load_use && !haz.redirect_ex;
    assign haz.flush = haz.redirect_ex;

endmodule

// ==== source/cpu.sv ====
`include "cpu_macros.svh"

module cpu (
    input  logic               clk,
    input  logic               rst,
    output logic [`XLEN-1:0]   im_addr,
    input  logic [`XLEN-1:0]   im_dout,
    output logic [`XLEN-1:0]   mem_addr,
    output logic               mem_we,
    output logic [`XLEN-1:0]   mem_din,
    input  logic [`XLEN-1:0]   mem_dout,
    input  logic [`REG_AW-1:0] dbg_addr,
    output logic [`XLEN-1:0]   dbg_data,
    output logic               ebreak
);
    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  if_id_pc;
    logic [`XLEN-1:0]  if_id_inst;
    cpu_pkg::id_ex_t   id_ex;
    cpu_pkg::ex_mem_t  ex_mem;
    cpu_pkg::mem_wb_t  mem_wb;

    cpu_pkg::ctrl_t    ctrl_id;
    logic [`XLEN-1:0]  imm_id;
    logic [`XLEN-1:0]  rs1_data_id, rs2_data_id;
    logic [`XLEN-1:0]  ex_result, ex_store_data, target;
    logic              redirect;
    logic [`XLEN-1:0]  wb_data;

    hazard_if haz ();

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= target;
        end else if (!haz.stall) begin
            pc <= pc + `XLEN'(4);
        end
    end

    assign im_addr = pc;

    // A zero word in IF/ID decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst || haz.flush) begin
            if_id_inst <= '0;
        end else if (!haz.stall) begin
            if_id_pc   <= pc;
            if_id_inst <= im_dout;
        end
    end

    decoder dec (
        .inst (if_id_inst),
        .ctrl (ctrl_id),
        .imm  (imm_id)
    );

    reg_file rf (
        .clk      (clk),
        .rst      (rst),
        .ra0      (haz.rs1_id),
        .ra1      (haz.rs2_id),
        .dbg_addr (dbg_addr),
        .rd0      (rs1_data_id),
        .rd1      (rs2_data_id),
        .dbg_data (dbg_data),
        .wa       (mem_wb.rd),
        .wd       (wb_data),
        .we       (mem_wb.ctrl.reg_we)
    );

    always_ff @(posedge clk) begin
        id_ex.pc       <= if_id_pc;
        id_ex.rs1      <= haz.rs1_id;
        id_ex.rs2      <= haz.rs2_id;
        id_ex.rd       <= if_id_inst[`RD_HI:`RD_LO];
        id_ex.rs1_data <= rs1_data_id;
        id_ex.rs2_data <= rs2_data_id;
        id_ex.imm      <= imm_id;
        if (rst || haz.flush || haz.stall) begin
            id_ex.ctrl <= '0;       // Bubble
        end else begin
            id_ex.ctrl <= ctrl_id;
        end
    end

    execute exu (
        .ex         (id_ex),
        .mem_result (ex_mem.result),
        .wb_result  (wb_data),
        .haz        (haz),
        .result     (ex_result),
        .store_data (ex_store_data),
        .redirect   (redirect),
        .target     (target)
    );

    always_ff @(posedge clk) begin
        ex_mem.result     <= ex_result;
        ex_mem.store_data <= ex_store_data;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.ctrl       <= rst ? '0 : id_ex.ctrl;
    end

    assign mem_addr = ex_mem.result;
    assign mem_din  = ex_mem.store_data;
    assign mem_we   = ex_mem.ctrl.mem_we;

    always_ff @(posedge clk) begin
        mem_wb.result    <= ex_mem.result;
        mem_wb.load_data <= mem_dout;
        mem_wb.rd        <= ex_mem.rd;
        mem_wb.ctrl      <= rst ? '0 : ex_mem.ctrl;
    end

    always_comb begin
        case (mem_wb.ctrl.wd_sel)
            cpu_pkg::WD_LOAD: wb_data = mem_wb.load_data;
            cpu_pkg::WD_ALU,
            cpu_pkg::WD_PC4:  wb_data = mem_wb.result;   // Link value made in EX
            default:          wb_data = '0;
        endcase
    end

    assign ebreak = mem_wb.ctrl.ebreak;

    // Stage fields for the hazard unit
    assign haz.rs1_id      = if_id_inst[`RS1_HI:`RS1_LO];
    assign haz.rs2_id      = if_id_inst[`RS2_HI:`RS2_LO];
    assign haz.rs1_re_id   = ctrl_id.rs1_re;
    assign haz.rs2_re_id   = ctrl_id.rs2_re;
    assign haz.rs1_ex      = id_ex.rs1;
    assign haz.rs2_ex      = id_ex.rs2;
    assign haz.rs1_re_ex   = id_ex.ctrl.rs1_re;
    assign haz.rs2_re_ex   = id_ex.ctrl.rs2_re;
    assign haz.rd_ex       = id_ex.rd;
    assign haz.mem_read_ex = id_ex.ctrl.mem_re;
    assign haz.rd_mem      = ex_mem.rd;
    assign haz.reg_we_mem  = ex_mem.ctrl.reg_we;
    assign haz.rd_wb       = mem_wb.rd;
    assign haz.reg_we_wb   = mem_wb.ctrl.reg_we;

    hazard_unit hzd (.haz(haz));

endmodule

// ==== dv/cpu_assert.sv ====
`include "cpu_macros.svh"

module cpu_assert (
    input logic               clk,
    input logic               rst,
    input logic               mem_we,
    input logic               ebreak,
    input logic [`XLEN-1:0]   pc,
    input logic               stall,
    input logic               redirect,
    input cpu_pkg::ctrl_t     id_ex_ctrl,
    input logic [`REG_AW-1:0] rs1_ex,
    input logic [`REG_AW-1:0] rs2_ex,
    input logic [`XLEN-1:0]   rs1_data_ex,
    input logic [`XLEN-1:0]   rs2_data_ex,
    input cpu_pkg::fwd_sel_e  fwd_a,
    input cpu_pkg::fwd_sel_e  fwd_b
);
    quiet_after_reset: assert property (@(posedge clk) rst |=> (!mem_we && !ebreak))
        else $error("mem_we or ebreak high during or right after reset");

    stall_holds_pc: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(pc))
        else $error("PC moved during a load-use stall");

    redirect_bubble: assert property (@(posedge clk) disable iff (rst)
        redirect |=> (id_ex_ctrl == '0))
        else $error("ID/EX not a bubble after a redirect");

    // x0 operands in EX come neither from a forward nor from a stored write
    x0_rs1_zero: assert property (@(posedge clk) disable iff (rst)
        (id_ex_ctrl.rs1_re && rs1_ex == '0) |->
            (fwd_a == cpu_pkg::FWD_NONE && rs1_data_ex == '0))
        else $error("Register 0 value reached the rs1 operand in EX");

    x0_rs2_zero: assert property (@(posedge clk) disable iff (rst)
        (id_ex_ctrl.rs2_re && rs2_ex == '0) |->
            (fwd_b == cpu_pkg::FWD_NONE && rs2_data_ex == '0))
        else $error("Register 0 value reached the rs2 operand in EX");
endmodule

bind cpu cpu_assert pipe_checks (
    .clk         (clk),
    .rst         (rst),
    .mem_we      (mem_we),
    .ebreak      (ebreak),
    .pc          (pc),
    .stall       (haz.stall),
    .redirect    (redirect),
    .id_ex_ctrl  (id_ex.ctrl),
    .rs1_ex      (id_ex.rs1),
    .rs2_ex      (id_ex.rs2),
    .rs1_data_ex (id_ex.rs1_data),
    .rs2_data_ex (id_ex.rs2_data),
    .fwd_a       (haz.fwd_a),
    .fwd_b       (haz.fwd_b)
);

// ==== dv/cpu_checker.sv ====
`include "cpu_macros.svh"

module cpu_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic [`XLEN-1:0]   im_addr,
    input  logic [`XLEN-1:0]   mem_addr,
    input  logic               mem_we,
    input  logic [`XLEN-1:0]   mem_din,
    input  logic               ebreak,
    input  logic [`REG_AW-1:0] dbg_addr,
    input  logic [`XLEN-1:0]   dbg_data,
    input  logic               check_req,
    input  logic               timed_out,
    input  logic               report,
    input  int                 test_id,
    input  logic [`XLEN-1:0]   exp_val,
    input  logic               exp_store,
    input  logic [`XLEN-1:0]   exp_addr,
    input  logic [`XLEN-1:0]   exp_data,
    output int                 pass_count,
    output int                 fail_count,
    output int                 other_errors
);
    logic             rst_seen;
    logic             store_seen;
    logic [`XLEN-1:0] seen_addr, seen_data;

    initial begin
        pass_count   = 0;
        fail_count   = 0;
        other_errors = 0;
        rst_seen     = 1'b0;
        store_seen   = 1'b0;
    end

    always @(negedge clk) begin
        // Reset has taken effect once rst was high at the previous edge
        if (rst && rst_seen) begin
            if (im_addr !== `RESET_PC || mem_we !== 1'b0 || ebreak !== 1'b0) begin
                $display("** Error at %0t: test %0d im_addr=%h mem_we=%b ebreak=%b in reset",
                         $time, test_id, im_addr, mem_we, ebreak);
                other_errors++;
            end
        end
        rst_seen = rst;

        if (rst) begin
            store_seen = 1'b0;
        end else if (mem_we === 1'b1) begin
            if (!exp_store) begin
                $display("** Error at %0t: test %0d unexpected store of %h to %h",
                         $time, test_id, mem_din, mem_addr);
                other_errors++;
            end
            store_seen = 1'b1;
            seen_addr  = mem_addr;
            seen_data  = mem_din;
        end

        if (check_req) begin
            if (timed_out) begin
                $display("test %0d failed: the program did not reach ebreak within 60 cycles",
                         test_id);
                fail_count++;
            end else if (dbg_data !== exp_val) begin
                $display("** Error at %0t: test %0d x%0d = %h, expected %h",
                         $time, test_id, dbg_addr, dbg_data, exp_val);
                fail_count++;
            end else if (exp_store && !store_seen) begin
                $display("test %0d failed: the expected store never happened", test_id);
                fail_count++;
            end else if (exp_store && (seen_addr !== exp_addr || seen_data !== exp_data)) begin
                $display("** Error at %0t: test %0d stored %h at %h, expected %h at %h",
                         $time, test_id, seen_data, seen_addr, exp_data, exp_addr);
                fail_count++;
            end else begin
                $display("test %0d passed: x%0d = %h", test_id, dbg_addr, dbg_data);
                pass_count++;
            end
        end

        if (report) begin
            $display("tests passed %0d, failed %0d, other errors %0d",
                     pass_count, fail_count, other_errors);
        end
    end
endmodule

// ==== dv/cpu_tb.sv ====
`include "cpu_macros.svh"

module cpu_tb;
    localparam int NT       = 9;
    localparam int MAX_WORDS = 12;
    localparam int WATCHDOG = NT * 80 * 40;

    logic               clk;
    logic               rst;
    logic [`XLEN-1:0]   im_addr, im_dout;
    logic [`XLEN-1:0]   mem_addr, mem_din, mem_dout;
    logic               mem_we;
    logic [`REG_AW-1:0] dbg_addr;
    logic [`XLEN-1:0]   dbg_data;
    logic               ebreak;

    logic               check_req, timed_out, report;
    int                 test_id;
    logic [`XLEN-1:0]   exp_val, exp_addr, exp_data;
    logic               exp_store;
    int                 pass_count, fail_count, other_errors;

    logic [31:0]        imem [64];
    logic [31:0]        dmem [64];

    // Test table
    logic [31:0]        prog [NT][MAX_WORDS];
    int                 prog_len [NT];
    logic [4:0]         inspect_reg [NT];
    logic [31:0]        expect_val [NT];
    logic               store_chk [NT];
    logic [31:0]        store_addr [NT];
    logic [31:0]        store_data [NT];

    cpu DUT (
        .clk      (clk),
        .rst      (rst),
        .im_addr  (im_addr),
        .im_dout  (im_dout),
        .mem_addr (mem_addr),
        .mem_we   (mem_we),
        .mem_din  (mem_din),
        .mem_dout (mem_dout),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data),
        .ebreak   (ebreak)
    );

    cpu_checker chk (
        .clk(clk), .rst(rst), .im_addr(im_addr), .mem_addr(mem_addr), .mem_we(mem_we),
        .mem_din(mem_din), .ebreak(ebreak), .dbg_addr(dbg_addr), .dbg_data(dbg_data),
        .check_req(check_req), .timed_out(timed_out), .report(report), .test_id(test_id),
        .exp_val(exp_val), .exp_store(exp_store), .exp_addr(exp_addr), .exp_data(exp_data),
        .pass_count(pass_count), .fail_count(fail_count), .other_errors(other_errors)
    );

    always #20 clk = ~clk;

    assign im_dout  = imem[im_addr[7:2]];
    assign mem_dout = dmem[mem_addr[7:2]];

    always @(posedge clk) begin
        if (mem_we) dmem[mem_addr[7:2]] <= mem_din;
    end

    function automatic logic [31:0] alu_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_word(input logic [2:0] f3, input int rd,
                                             input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
        return imm_word(3'b000, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] lw_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input int rs1,
                                                input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] lui_word(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] jal_word(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Data memory contents before each test
    function automatic logic [31:0] fill_value(input int byte_addr);
        return 32'hc0de_0000 | byte_addr;
    endfunction

    task automatic add_word(input int t, input logic [31:0] w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic expect_reg(input int t, input int r, input logic [31:0] v);
        inspect_reg[t] = r[4:0];
        expect_val[t]  = v;
        store_chk[t]   = 1'b0;
        store_addr[t]  = '0;
        store_data[t]  = '0;
    endtask

    task automatic build_table();
        for (int t = 0; t < NT; t++) prog_len[t] = 0;
        // Test 0 drops writes to x0
        add_word(0, addi_word(0, 0, 123));
        add_word(0, addi_word(1, 0, 7));
        add_word(0, alu_word(7'h00, 3'b000, 0, 1, 1));
        expect_reg(0, 0, 32'h0);
        // Test 1 is a dependent chain through MEM and WB forwarding
        add_word(1, addi_word(1, 0, 5));
        add_word(1, addi_word(2, 1, 3));
        add_word(1, alu_word(7'h00, 3'b000, 3, 1, 2));     // 13
        add_word(1, alu_word(7'h20, 3'b000, 4, 3, 1));     // 8
        add_word(1, alu_word(7'h00, 3'b100, 5, 4, 3));     // 5
        add_word(1, alu_word(7'h00, 3'b010, 6, 5, 4));     // 1
        add_word(1, alu_word(7'h00, 3'b000, 7, 6, 5));
        expect_reg(1, 7, 32'd6);
        // Test 2 uses immediate ops with negative values
        add_word(2, addi_word(1, 0, -3));
        add_word(2, imm_word(3'b010, 2, 1, -2));            // slti gives 1
        add_word(2, imm_word(3'b100, 3, 1, 12'h0ff));
        add_word(2, imm_word(3'b110, 4, 3, 12'h0f0));
        add_word(2, alu_word(7'h00, 3'b000, 5, 4, 2));
        add_word(2, imm_word(3'b111, 6, 5, 12'h7ff));
        expect_reg(2, 6, 32'h0000_07f3);
        // Test 3 covers store, load and load-use
        add_word(3, addi_word(1, 0, 40));
        add_word(3, addi_word(2, 0, 100));
        add_word(3, sw_word(2, 1, 8));
        add_word(3, lw_word(3, 1, 8));
        add_word(3, alu_word(7'h00, 3'b000, 4, 3, 2));
        expect_reg(3, 4, 32'd200);
        store_chk[3]  = 1'b1;
        store_addr[3] = 32'd48;
        store_data[3] = 32'd100;
        // Test 4 mixes taken and not-taken beq, bne, blt
        add_word(4, addi_word(1, 0, 1));
        add_word(4, addi_word(2, 0, 2));
        add_word(4, branch_word(3'b000, 1, 2, 8));
        add_word(4, addi_word(3, 0, 10));
        add_word(4, branch_word(3'b001, 1, 2, 8));
        add_word(4, addi_word(3, 3, 100));
        add_word(4, branch_word(3'b100, 2, 1, 8));
        add_word(4, addi_word(3, 3, 5));
        add_word(4, branch_word(3'b100, 1, 2, 8));
        add_word(4, addi_word(3, 3, 1000));
        expect_reg(4, 3, 32'd15);
        // Test 5 has a not-taken bne, then a taken beq skipping two
        add_word(5, addi_word(1, 0, 4));
        add_word(5, addi_word(2, 0, 4));
        add_word(5, branch_word(3'b001, 1, 2, 8));
        add_word(5, addi_word(5, 0, 1));
        add_word(5, branch_word(3'b000, 1, 2, 12));
        add_word(5, addi_word(5, 0, 2));
        add_word(5, addi_word(5, 0, 3));
        add_word(5, addi_word(5, 5, 9));
        expect_reg(5, 5, 32'd10);
        // Test 6 runs lui then jal over two words
        add_word(6, lui_word(1, 20'h12345));
        add_word(6, jal_word(2, 12));
        add_word(6, addi_word(1, 0, 0));
        add_word(6, addi_word(1, 0, 0));
        add_word(6, alu_word(7'h00, 3'b000, 3, 1, 2));
        expect_reg(6, 3, 32'h1234_5008);
        // Test 7 checks the jal link value
        add_word(7, jal_word(5, 8));
        add_word(7, addi_word(5, 0, 99));
        expect_reg(7, 5, 32'd4);
        // Test 8 uses negative offsets and a preloaded word
        add_word(8, addi_word(1, 0, 64));
        add_word(8, addi_word(2, 0, -5));
        add_word(8, sw_word(2, 1, -4));
        add_word(8, lw_word(3, 1, -4));
        add_word(8, lw_word(4, 0, 12));
        add_word(8, alu_word(7'h20, 3'b000, 5, 4, 3));     // fill(12) + 5
        expect_reg(8, 5, fill_value(12) + 32'd5);
        store_chk[8]  = 1'b1;
        store_addr[8] = 32'd60;
        store_data[8] = 32'hffff_fffb;
        for (int t = 0; t < NT; t++) add_word(t, `EBREAK_WORD);
    endtask

    task automatic load_memories(input int t);
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog_len[t]) ? prog[t][i] : 32'h0;
            dmem[i] = fill_value(i * 4);
        end
    endtask

    task automatic run_test(input int t);
        int  cycles;
        logic seen;
        @(posedge clk);
        rst       <= 1'b1;
        test_id   <= t;
        exp_val   <= expect_val[t];
        exp_store <= store_chk[t];
        exp_addr  <= store_addr[t];
        exp_data  <= store_data[t];
        @(posedge clk);
        load_memories(t);
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 60) begin
            @(negedge clk);
            if (ebreak) seen = 1'b1;
            else cycles++;
        end
        @(posedge clk);
        dbg_addr  <= inspect_reg[t];
        timed_out <= !seen;
        check_req <= 1'b1;
        @(posedge clk);
        check_req <= 1'b0;
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        dbg_addr  = '0;
        check_req = 1'b0;
        timed_out = 1'b0;
        report    = 1'b0;
        test_id   = 0;
        exp_val   = '0;
        exp_store = 1'b0;
        exp_addr  = '0;
        exp_data  = '0;
        build_table();
        load_memories(0);
        for (int t = 0; t < NT; t++) run_test(t);
        @(posedge clk);
        report <= 1'b1;
        @(posedge clk);
        report <= 1'b0;
        @(posedge clk);
        if (fail_count == 0 && other_errors == 0 && pass_count == NT) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG);
        $display("watchdog expired before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end
endmodule

// ==== flist.f ====
+incdir+source
source/cpu_pkg.sv
source/hazard_if.sv
source/decoder.sv
source/reg_file.sv
source/execute.sv
source/hazard_unit.sv
source/cpu.sv
dv/cpu_assert.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module cpu_tb \
    -o cpu_sim

sim_out=$(./obj_dir/cpu_sim)
echo "$sim_out"

# Pass only when the testbench printed its pass line
grep -qx "NO ERRORS" <<< "$sim_out"
